//--- dv/core_trace.txt
# P <address> <word>: program word loaded into instruction memory.
# R <pc> <instruction> <rd> <data>: expected retire, in program order.
# all fields hex; text after the fields is ignored. wrong-path words have no R line.
P 80000000 00500093  # addi x1, x0, 5.
P 80000004 ffd00113  # addi x2, x0, -3.
P 80000008 002081b3  # add  x3, x1, x2, forwards from execute and memory slot.
P 8000000c 40118233  # sub  x4, x3, x1, x1 through the rf bypass.
P 80000010 001122b3  # slt  x5, x2, x1.
P 80000014 00113333  # sltu x6, x2, x1.
P 80000018 40115393  # srai x7, x2, 1.
P 8000001c 00115413  # srli x8, x2, 1.
P 80000020 123454b7  # lui  x9, 0x12345.
P 80000024 00001517  # auipc x10, 0x1.
P 80000028 00708013  # addi x0, x1, 7, no retire.
P 8000002c 001005b3  # add  x11, x0, x1.
P 80000030 00108663  # beq  x1, x1, +12, taken.
P 80000034 06300713  # addi x14, x0, 99, wrong path.
P 80000038 06200793  # addi x15, x0, 98, wrong path.
P 8000003c 00109663  # bne  x1, x1, +12, falls through.
P 80000040 00100613  # addi x12, x0, 1.
P 80000044 00c006ef  # jal  x13, +12.
P 80000048 06300713  # wrong path.
P 8000004c 06200793  # wrong path.
P 80000050 00000817  # auipc x16, 0.
P 80000054 011808e7  # jalr x17, 17(x16), bit 0 of the target dropped.
P 80000058 06300713  # wrong path.
P 8000005c 06200793  # wrong path.
P 80000060 00c8e933  # or   x18, x17, x12.
P 80000064 401159b3  # sra  x19, x2, x1.
P 80000068 00114663  # blt  x2, x1, +12, taken.
P 8000006c 06300713  # wrong path.
P 80000070 06200793  # wrong path.
P 80000074 01394a33  # xor  x20, x18, x19.
P 80000078 0020f663  # bgeu x1, x2, +12, falls through.
P 8000007c fffa0a93  # addi x21, x20, -1.
P 80000080 0000006f  # jal  x0, 0, parks the core.
R 80000000 00500093 01 00000005
R 80000004 ffd00113 02 fffffffd
R 80000008 002081b3 03 00000002
R 8000000c 40118233 04 fffffffd
R 80000010 001122b3 05 00000001
R 80000014 00113333 06 00000000
R 80000018 40115393 07 fffffffe
R 8000001c 00115413 08 7ffffffe
R 80000020 123454b7 09 12345000
R 80000024 00001517 0a 80001024
R 8000002c 001005b3 0b 00000005
R 80000040 00100613 0c 00000001
R 80000044 00c006ef 0d 80000048
R 80000050 00000817 10 80000050
R 80000054 011808e7 11 80000058
R 80000060 00c8e933 12 80000059
R 80000064 401159b3 13 ffffffff
R 80000074 01394a33 14 7fffffa6
R 8000007c fffa0a93 15 7fffffa5

//--- dv/tb_rv_core_top.sv
`timescale 1ns/1ps

module tb_rv_core_top import core_cfg_pkg::*; ();

    localparam word_t RESET_PC     = DEFAULT_RESET_PC;
    localparam int    MEM_WORDS    = 256;                  // 1 KiB program window.
    localparam int    DRAIN_CYCLES = 20;                   // quiet cycles after the last retire.
    localparam string TRACE_FILE   = "dv/core_trace.txt";

    logic     clk;
    logic     rstn;
    word_t    imem_data = '0;  // sync rom output, driven on the rising edge.
    word_t    imem_addr;
    logic     retire_valid;
    word_t    retire_pc;
    word_t    retire_instr;
    reg_idx_t retire_rd;
    word_t    retire_data;

    word_t    imem [MEM_WORDS];
    word_t    exp_pc_q [$];     // expected retires, oldest first.
    word_t    exp_instr_q [$];
    reg_idx_t exp_rd_q [$];
    word_t    exp_data_q [$];
    int       prog_words   = 0;
    int       setup_errs   = 0;  // trace file problems.
    int       mismatch_cnt = 0;
    int       other_cnt    = 0;
    int       retired_cnt  = 0;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) i_rv_core_top (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .imem_data_i    (imem_data),
        .imem_addr_o    (imem_addr),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_instr_o (retire_instr),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    function automatic int mem_index(word_t addr);
        return int'(((addr - RESET_PC) >> 2) & word_t'(MEM_WORDS - 1));  // word offset, wraps.
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = word_t'(i) << 7;  // opcode field zero, so stray fetches do nothing.
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        byte   tag;
        string line;
        string body;
        word_t f0;
        word_t f1;
        word_t f2;
        word_t f3;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %s", TRACE_FILE);
            setup_errs++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            tag = line.getc(0);
            if ((tag == "P") || (tag == "R")) begin
                body = line.substr(1, line.len() - 1);  // drop the tag.
                n    = $sscanf(body, "%h %h %h %h", f0, f1, f2, f3);
                if ((tag == "P") && (n >= 2)) begin
                    imem[mem_index(f0)] = f1;
                    prog_words++;
                end else if ((tag == "R") && (n == 4)) begin
                    exp_pc_q.push_back(f0);
                    exp_instr_q.push_back(f1);
                    exp_rd_q.push_back(reg_idx_t'(f2));
                    exp_data_q.push_back(f3);
                end else begin
                    $display("malformed trace line: %s", line);
                    setup_errs++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz.
    end

    always @(posedge clk) begin
        imem_data <= imem[mem_index(imem_addr)];  // one cycle read latency.
    end

    // retire outputs are registered, so they are steady at the falling edge.
    always @(negedge clk) begin
        word_t    exp_pc;
        word_t    exp_instr;
        reg_idx_t exp_rd;
        word_t    exp_data;
        if (!rstn) begin
            check_value("retire_valid_o during reset", word_t'(retire_valid), '0);
        end else if ($isunknown(retire_valid)) begin
            $display("retire_valid_o is unknown at %0t", $time);
            other_cnt++;
        end else if (retire_valid) begin
            if (exp_pc_q.size() == 0) begin
                $display("retire of pc %h at %0t has no expected record left", retire_pc, $time);
                other_cnt++;
            end else begin
                exp_pc    = exp_pc_q.pop_front();
                exp_instr = exp_instr_q.pop_front();
                exp_rd    = exp_rd_q.pop_front();
                exp_data  = exp_data_q.pop_front();
                if (retired_cnt == 0) begin
                    check_value("first retire pc", retire_pc, RESET_PC);  // pipeline starts here.
                end
                check_value($sformatf("retire %0d pc", retired_cnt), retire_pc, exp_pc);
                check_value($sformatf("pc %h instr", exp_pc), retire_instr, exp_instr);
                check_value($sformatf("pc %h rd", exp_pc), word_t'(retire_rd), word_t'(exp_rd));
                check_value($sformatf("pc %h data", exp_pc), retire_data, exp_data);
                retired_cnt++;
            end
        end
    end

    initial begin
        int   cycles;
        int   idle;
        int   limit;
        int   end_errs;
        logic timed_out;
        rstn      = 1'b0;
        end_errs  = 0;
        cycles    = 0;
        idle      = 0;
        timed_out = 1'b0;
        fill_memory();
        load_trace();
        limit = 8 * prog_words + 50;  // generous bound, no program word runs that long.
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        while ((idle < DRAIN_CYCLES) && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (exp_pc_q.size() == 0) begin
                idle++;  // watch for extra retires after the last record.
            end
            if (cycles >= limit) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("timeout after %0d cycles, the program did not finish", cycles);
            end_errs++;
        end
        if (exp_pc_q.size() != 0) begin
            $display("%0d expected retires never appeared", exp_pc_q.size());
            end_errs++;
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d retires checked",
                 mismatch_cnt, other_cnt + setup_errs + end_errs, retired_cnt);
        if ((mismatch_cnt == 0) && (other_cnt + setup_errs + end_errs == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/core_cfg_pkg.sv
package core_cfg_pkg;

    typedef logic [31:0] word_t;    // datapath word.
    typedef logic [4:0]  reg_idx_t; // x0 .. x31.

    // where execute takes a source operand from.
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // decode/execute slot, already bypassed by the rf.
        FWD_EX   = 2'd1,  // execute/memory register.
        FWD_MEM  = 2'd2   // memory/writeback register.
    } fwd_sel_e;

    // first fetch address, same as spike.
    localparam word_t DEFAULT_RESET_PC = 32'h8000_0000;

endpackage

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_cfg_pkg::*, rv32_isa_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     redirect_valid_i,
    input  word_t    fd_pc_i,
    input  word_t    fd_instr_i,
    input  logic     wb_rd_we_i,   // write port from the memory slot.
    input  reg_idx_t wb_rd_i,
    input  word_t    wb_data_i,
    output word_t    de_pc_o,
    output word_t    de_instr_o,
    output word_t    de_imm_o,
    output word_t    de_rs1_data_o,
    output word_t    de_rs2_data_o
);

    opcode_e opcode;
    word_t   imm;
    word_t   rs1_data;
    word_t   rs2_data;

    assign opcode = opcode_e'(fd_instr_i[6:0]);

    always_comb begin
        case (opcode)
            LUI, AUIPC: begin
                imm = {fd_instr_i[31:12], 12'b0};  // u-type.
            end
            JAL: begin
                imm = {{12{fd_instr_i[31]}}, fd_instr_i[19:12], fd_instr_i[20],
                       fd_instr_i[30:21], 1'b0};  // j-type.
            end
            JALR, OP_IMM: begin
                imm = {{20{fd_instr_i[31]}}, fd_instr_i[31:20]};  // i-type, shamt in [4:0].
            end
            BRANCH: begin
                imm = {{20{fd_instr_i[31]}}, fd_instr_i[7], fd_instr_i[30:25],
                       fd_instr_i[11:8], 1'b0};  // b-type.
            end
            default: imm = '0;  // op has no immediate.
        endcase
    end

    register_file i_register_file (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (wb_rd_we_i),
        .waddr_i  (wb_rd_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (fd_instr_i[19:15]),
        .raddr2_i (fd_instr_i[24:20]),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            de_instr_o <= '0;
        end else if (redirect_valid_i) begin
            de_instr_o <= '0;  // drop the wrong-path slot.
        end else begin
            de_instr_o <= fd_instr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        de_pc_o       <= fd_pc_i;
        de_imm_o      <= imm;
        de_rs1_data_o <= rs1_data;
        de_rs2_data_o <= rs2_data;
    end

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_cfg_pkg::*, rv32_isa_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  word_t    de_pc_i,
    input  word_t    de_instr_i,
    input  word_t    de_imm_i,
    input  word_t    de_rs1_data_i,
    input  word_t    de_rs2_data_i,
    input  logic     wb_rd_we_i,
    input  reg_idx_t wb_rd_i,
    input  word_t    wb_data_i,
    output logic     redirect_valid_o,
    output word_t    redirect_pc_o,
    output word_t    ex_pc_o,
    output word_t    ex_instr_o,
    output word_t    ex_result_o,
    output reg_idx_t ex_rd_o,
    output logic     ex_rd_we_o
);

    opcode_e  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    reg_idx_t rd;
    fwd_sel_e fwd_rs1;
    fwd_sel_e fwd_rs2;
    word_t    op_a;
    word_t    rs2_val;
    word_t    op_b;      // immediate for op_imm, rs2 otherwise.
    word_t    pc_rel;    // pc + imm.
    word_t    sra_res;
    word_t    alu;
    word_t    result;
    logic     alt;       // sub or arithmetic shift.
    logic     taken;
    logic     writes;

    assign opcode = opcode_e'(de_instr_i[6:0]);
    assign funct3 = de_instr_i[14:12];
    assign funct7 = de_instr_i[31:25];
    assign rd     = de_instr_i[11:7];

    forward_unit i_forward_unit (
        .rs1_i      (de_instr_i[19:15]),
        .rs2_i      (de_instr_i[24:20]),
        .ex_rd_i    (ex_rd_o),
        .ex_rd_we_i (ex_rd_we_o),
        .wb_rd_i    (wb_rd_i),
        .wb_rd_we_i (wb_rd_we_i),
        .fwd_rs1_o  (fwd_rs1),
        .fwd_rs2_o  (fwd_rs2)
    );

    always_comb begin
        case (fwd_rs1)
            FWD_EX:  op_a = ex_result_o;
            FWD_MEM: op_a = wb_data_i;
            default: op_a = de_rs1_data_i;
        endcase
        case (fwd_rs2)
            FWD_EX:  rs2_val = ex_result_o;
            FWD_MEM: rs2_val = wb_data_i;
            default: rs2_val = de_rs2_data_i;
        endcase
    end

    assign op_b    = (opcode == OP_IMM) ? de_imm_i : rs2_val;
    assign pc_rel  = de_pc_i + de_imm_i;
    assign alt     = (funct7 == F7_ALT) && ((opcode == OP) || (funct3 == F3_SRL_SRA));
    assign sra_res = $signed(op_a) >>> op_b[4:0];  // shift amount is 5 bits.

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu = alt ? (op_a - op_b) : (op_a + op_b);
            F3_SLL:     alu = op_a << op_b[4:0];
            F3_SLT:     alu = {31'b0, $signed(op_a) < $signed(op_b)};
            F3_SLTU:    alu = {31'b0, op_a < op_b};
            F3_XOR:     alu = op_a ^ op_b;
            F3_SRL_SRA: alu = alt ? sra_res : (op_a >> op_b[4:0]);
            F3_OR:      alu = op_a | op_b;
            default:    alu = op_a & op_b;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (op_a == op_b);
            F3_BNE:  taken = (op_a != op_b);
            F3_BLT:  taken = ($signed(op_a) < $signed(op_b));
            F3_BGE:  taken = ($signed(op_a) >= $signed(op_b));
            F3_BLTU: taken = (op_a < op_b);
            F3_BGEU: taken = (op_a >= op_b);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        result           = alu;
        writes           = 1'b0;
        redirect_valid_o = 1'b0;
        redirect_pc_o    = pc_rel;  // jal and branch target.
        case (opcode)
            LUI: begin
                result = de_imm_i;
                writes = 1'b1;
            end
            AUIPC: begin
                result = pc_rel;
                writes = 1'b1;
            end
            JAL: begin
                result           = de_pc_i + 32'd4;  // link value.
                writes           = 1'b1;
                redirect_valid_o = 1'b1;
            end
            JALR: begin
                result           = de_pc_i + 32'd4;
                writes           = 1'b1;
                redirect_valid_o = 1'b1;
                redirect_pc_o    = (op_a + de_imm_i) & ~32'd1;  // bit 0 cleared.
            end
            BRANCH:  redirect_valid_o = taken;
            OP_IMM:  writes = 1'b1;
            OP:      writes = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            default: ;  // zero slot does nothing.
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ex_instr_o <= '0;
            ex_rd_we_o <= 1'b0;
        end else begin
            ex_instr_o <= de_instr_i;
            ex_rd_we_o <= writes && (rd != '0);  // rd x0 never writes.
        end
    end

    always_ff @(posedge clk_i) begin
        ex_pc_o     <= de_pc_i;
        ex_rd_o     <= rd;
        ex_result_o <= result;
    end

    a_redirect_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_valid_o |-> (redirect_pc_o[0] == 1'b0));

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_cfg_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  redirect_valid_i,  // taken branch or jump in execute.
    input  word_t redirect_pc_i,
    input  word_t imem_data_i,       // word of pc_q, one clock after its address.
    output word_t imem_addr_o,
    output word_t fd_pc_o,
    output word_t fd_instr_o
);

    word_t pc_q;         // pc whose word is on imem_data_i.
    word_t pc_d;
    logic  fetch_vld_q;  // low for one cycle after reset while the first word is read.

    always_comb begin
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;  // target goes out in the same cycle.
        end else if (fetch_vld_q) begin
            pc_d = pc_q + 32'd4;
        end else begin
            pc_d = pc_q;  // fetch the reset pc once more.
        end
    end

    assign imem_addr_o = pc_d;  // sync rom, data returns next cycle.

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q        <= RESET_PC;
            fetch_vld_q <= 1'b0;
        end else begin
            pc_q        <= pc_d;
            fetch_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fd_instr_o <= '0;
        end else if (redirect_valid_i || !fetch_vld_q) begin
            fd_instr_o <= '0;  // zero instruction, matches no opcode.
        end else begin
            fd_instr_o <= imem_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        fd_pc_o <= pc_q;
    end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pc_q[1:0] == 2'b00);

endmodule

//--- hdl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import core_cfg_pkg::*; (
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t ex_rd_i,     // producer one ahead.
    input  logic     ex_rd_we_i,
    input  reg_idx_t wb_rd_i,     // producer two ahead.
    input  logic     wb_rd_we_i,
    output fwd_sel_e fwd_rs1_o,
    output fwd_sel_e fwd_rs2_o
);

    function automatic fwd_sel_e pick_src(reg_idx_t rs, reg_idx_t ex_rd, logic ex_we,
                                          reg_idx_t wb_rd, logic wb_we);
        if (ex_we && (ex_rd == rs)) begin
            return FWD_EX;    // youngest producer wins.
        end else if (wb_we && (wb_rd == rs)) begin
            return FWD_MEM;
        end
        return FWD_NONE;      // older value came through the rf bypass.
    endfunction

    assign fwd_rs1_o = pick_src(rs1_i, ex_rd_i, ex_rd_we_i, wb_rd_i, wb_rd_we_i);
    assign fwd_rs2_o = pick_src(rs2_i, ex_rd_i, ex_rd_we_i, wb_rd_i, wb_rd_we_i);

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file import core_cfg_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  word_t    wdata_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    word_t regs [32];  // entry 0 stays zero after reset.

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 32; i++) begin  // x1 .. x31 only.
                if (we_i && (waddr_i == reg_idx_t'(i))) begin
                    regs[i] <= wdata_i;
                end
            end
        end
    end

    // same-cycle write is visible to the reader.
    assign rdata1_o = (we_i && (waddr_i == raddr1_i)) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (we_i && (waddr_i == raddr2_i)) ? wdata_i : regs[raddr2_i];

    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        we_i |-> (waddr_i != '0));

endmodule

//--- hdl/retire_stage.sv
`timescale 1ns/1ps

module retire_stage import core_cfg_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  word_t    ex_pc_i,
    input  word_t    ex_instr_i,
    input  word_t    ex_result_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_rd_we_i,
    output logic     wb_rd_we_o,    // rf write and memory-slot forward source.
    output reg_idx_t wb_rd_o,
    output word_t    wb_data_o,
    output logic     retire_valid_o,
    output word_t    retire_pc_o,
    output word_t    retire_instr_o,
    output word_t    retire_data_o,
    output reg_idx_t retire_rd_o
);

    word_t    pc_q;
    word_t    instr_q;
    word_t    data_q;
    reg_idx_t rd_q;
    logic     rd_we_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            instr_q <= '0;
            rd_we_q <= 1'b0;
        end else begin
            instr_q <= ex_instr_i;
            rd_we_q <= ex_rd_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q   <= ex_pc_i;
        rd_q   <= ex_rd_i;
        data_q <= ex_result_i;
    end

    assign wb_rd_we_o     = rd_we_q;
    assign wb_rd_o        = rd_q;
    assign wb_data_o      = data_q;
    assign retire_valid_o = rd_we_q;  // report exactly the rf writes.
    assign retire_pc_o    = pc_q;
    assign retire_instr_o = instr_q;
    assign retire_data_o  = data_q;
    assign retire_rd_o    = rd_q;

    a_retire_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o |-> !$isunknown(retire_data_o));

endmodule

//--- hdl/rv32_isa_pkg.sv
package rv32_isa_pkg;

    typedef logic [2:0] funct3_t;  // instr[14:12].
    typedef logic [6:0] funct7_t;  // instr[31:25].

    // major opcodes in instr[6:0].
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,  // load upper immediate.
        AUIPC  = 7'b0010111,  // add upper immediate to pc.
        JAL    = 7'b1101111,  // jump and link.
        JALR   = 7'b1100111,  // jump and link register.
        BRANCH = 7'b1100011,  // conditional branches.
        OP_IMM = 7'b0010011,  // register-immediate alu.
        OP     = 7'b0110011   // register-register alu.
    } opcode_e;

    // branch conditions.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // alu operations, shared by op and op_imm.
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;  // add, srl, srli.
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub, sra, srai.

endpackage

//--- hdl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import core_cfg_pkg::*; #(
    parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  word_t    imem_data_i,
    output word_t    imem_addr_o,
    output logic     retire_valid_o,
    output word_t    retire_pc_o,
    output word_t    retire_instr_o,
    output reg_idx_t retire_rd_o,
    output word_t    retire_data_o
);

    logic     redirect_valid;  // from execute to fetch and decode.
    word_t    redirect_pc;
    word_t    fd_pc;
    word_t    fd_instr;
    word_t    de_pc;
    word_t    de_instr;
    word_t    de_imm;
    word_t    de_rs1_data;
    word_t    de_rs2_data;
    word_t    ex_pc;
    word_t    ex_instr;
    word_t    ex_result;
    reg_idx_t ex_rd;
    logic     ex_rd_we;
    logic     wb_rd_we;
    reg_idx_t wb_rd;
    word_t    wb_data;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch_stage (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .imem_data_i      (imem_data_i),
        .imem_addr_o      (imem_addr_o),
        .fd_pc_o          (fd_pc),
        .fd_instr_o       (fd_instr)
    );

    decode_stage i_decode_stage (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid),
        .fd_pc_i          (fd_pc),
        .fd_instr_i       (fd_instr),
        .wb_rd_we_i       (wb_rd_we),
        .wb_rd_i          (wb_rd),
        .wb_data_i        (wb_data),
        .de_pc_o          (de_pc),
        .de_instr_o       (de_instr),
        .de_imm_o         (de_imm),
        .de_rs1_data_o    (de_rs1_data),
        .de_rs2_data_o    (de_rs2_data)
    );

    execute_stage i_execute_stage (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .de_pc_i          (de_pc),
        .de_instr_i       (de_instr),
        .de_imm_i         (de_imm),
        .de_rs1_data_i    (de_rs1_data),
        .de_rs2_data_i    (de_rs2_data),
        .wb_rd_we_i       (wb_rd_we),
        .wb_rd_i          (wb_rd),
        .wb_data_i        (wb_data),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .ex_pc_o          (ex_pc),
        .ex_instr_o       (ex_instr),
        .ex_result_o      (ex_result),
        .ex_rd_o          (ex_rd),
        .ex_rd_we_o       (ex_rd_we)
    );

    retire_stage i_retire_stage (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .ex_pc_i          (ex_pc),
        .ex_instr_i       (ex_instr),
        .ex_result_i      (ex_result),
        .ex_rd_i          (ex_rd),
        .ex_rd_we_i       (ex_rd_we),
        .wb_rd_we_o       (wb_rd_we),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_instr_o   (retire_instr_o),
        .retire_data_o    (retire_data_o),
        .retire_rd_o      (retire_rd_o)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the rv_core_top testbench with verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_rv_core_top -f rv_core_top.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_core_top > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '>>> FAIL' "$log"; then
    exit 1
fi
if ! grep -q '>>> PASS' "$log"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

//--- rv_core_top.f
hdl/core_cfg_pkg.sv
hdl/rv32_isa_pkg.sv
hdl/register_file.sv
hdl/forward_unit.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/retire_stage.sv
hdl/rv_core_top.sv
dv/tb_rv_core_top.sv
